//--- flist.f
src/kem_ctrl_pkg.sv
src/kem_ctrl_ifs.sv
src/phase_planner.sv
src/step_sequencer.sv
src/unit_expander.sv
src/kem_ctrl_top.sv
verif/kem_ctrl_props.sv
verif/kem_ctrl_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the KEM controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module kem_ctrl_tb -o kem_ctrl_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/kem_ctrl_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Result: PASSED"; then
  exit 0
else
  exit 1
fi

//--- src/kem_ctrl_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// One phase per transfer from planner to sequencer
interface phase_if;
  import kem_ctrl_pkg::*;

  logic             valid;
  logic             ready;
  phase_e           phase;
  logic [ROW_W-1:0] row;

  modport src (output valid, output phase, output row, input ready);
  modport dst (input valid, input phase, input row, output ready);
endinterface

// One micro-step per transfer from sequencer to expander
interface step_if;
  import kem_ctrl_pkg::*;

  logic  valid;
  logic  ready;
  step_t step;
  // High on the final step of a phase
  logic  phase_end;

  modport src (output valid, output step, output phase_end, input ready);
  modport dst (input valid, input step, input phase_end, output ready);
endinterface

`default_nettype wire

//--- src/kem_ctrl_pkg.sv
`default_nettype none

package kem_ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Commands, phases and expansion opcodes
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    CMD_KEYGEN      = 2'd0,
    CMD_SETUP_TEST  = 2'd1,
    CMD_ADD_ENTROPY = 2'd2
  } kem_cmd_e;

  typedef enum logic [2:0] {
    PH_KEYGEN_PRNG   = 3'd0,
    PH_KEYGEN_SEEDED = 3'd1,
    PH_KEYGEN_MID    = 3'd2,
    PH_GEN_ROWS      = 3'd3,
    PH_KEYGEN_POST   = 3'd4,
    PH_SETUP_TEST    = 3'd5,
    PH_ADD_ENTROPY   = 3'd6
  } phase_e;

  typedef enum logic [3:0] {
    SK_GENERIC      = 4'd0,
    SK_ABSORB_BYTE  = 4'd1,
    SK_ABSORB_ZEROS = 4'd2,
    SK_K_SINGLE     = 4'd3,
    SK_K_LONG_OUT   = 4'd4,
    SK_K_LONG_IN    = 4'd5,
    SK_K_NO_OVERLAP = 4'd6,
    SK_MEM_OP       = 4'd7,
    SK_GEN_ROW_OUT  = 4'd8
  } step_kind_e;

  // Memory opcodes used by the keygen, setupTest and addEntropy phases
  typedef enum logic [4:0] {
    MEM_NONE           = 5'd0,
    MEM_OUT_RNG_STATE  = 5'd1,
    MEM_IN_RNG_STATE   = 5'd2,
    MEM_IN_SEED_SE     = 5'd3,
    MEM_OUT_SEED_SE    = 5'd4,
    MEM_OUT_U          = 5'd5,
    MEM_IN_U           = 5'd6,
    MEM_IN_SALT        = 5'd7,
    MEM_IN_S_ROW       = 5'd8,
    MEM_IN_B_COL       = 5'd9,
    MEM_OUT_B_COL      = 5'd10,
    MEM_OP_B_PLUS_S_AT = 5'd11,
    MEM_OP_ERASE1      = 5'd12
  } mem_cmd_e;

  ////////////////////////////////////////////////////////////////////////////
  // Hub routing and the step word
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [3:0] hub_t;

  localparam hub_t HUB_NONE   = 4'b0000;
  localparam hub_t HUB_KECCAK = 4'b0001;
  localparam hub_t HUB_OUTER  = 4'b0010;
  localparam hub_t HUB_MEM    = 4'b0100;
  localparam hub_t HUB_SEED   = 4'b1000;

  typedef struct packed {
    step_kind_e kind;
    logic       last;
    logic       sampled;
    logic [8:0] param;
    mem_cmd_e   mem;
    logic       pack;
    hub_t       dst;
    hub_t       src;
  } step_t;

  // Unit-select mask bit positions
  localparam int UNIT_W     = 8;
  localparam int UNIT_K     = 0;
  localparam int UNIT_H     = 1;
  localparam int UNIT_M     = 2;
  localparam int UNIT_S     = 3;
  localparam int UNIT_K_IN  = 4;
  localparam int UNIT_K_OUT = 5;
  localparam int UNIT_O_IN  = 6;
  localparam int UNIT_O_OUT = 7;

  localparam int GEN_ROWS  = 4;
  localparam int ROW_W     = 16;
  localparam int CREDITS   = 4;
  localparam int CREDIT_W  = 3;
  localparam int MAX_STEPS = 10;
  localparam int STEP_W    = 4;
  localparam int IN_WORDS  = 16;
  localparam int OUT_WORDS = 4;
  localparam int WORDS_W   = 5;

endpackage

`default_nettype wire

//--- src/kem_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module kem_ctrl_top (
  input  logic                             clk,
  input  logic                             i_rst_n,
  input  logic                             i_cmd_valid,
  input  kem_ctrl_pkg::kem_cmd_e           i_cmd,
  input  logic                             i_credit,
  output logic                             o_cmd_ready,
  output logic                             o_op_valid,
  output kem_ctrl_pkg::step_t              o_op,
  output logic [kem_ctrl_pkg::UNIT_W-1:0]  o_op_units,
  output logic [kem_ctrl_pkg::WORDS_W-1:0] o_op_in_words,
  output logic [kem_ctrl_pkg::WORDS_W-1:0] o_op_out_words
);
  import kem_ctrl_pkg::*;

  phase_if u_phase_if ();
  step_if  u_step_if ();

  // Command to phases
  phase_planner u_phase_planner (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_cmd_valid (i_cmd_valid),
    .i_cmd       (i_cmd),
    .o_cmd_ready (o_cmd_ready),
    .phase       (u_phase_if.src)
  );

  // Phases to micro-steps
  step_sequencer u_step_sequencer (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .phase   (u_phase_if.dst),
    .step    (u_step_if.src)
  );

  // Micro-steps to core operations
  unit_expander u_unit_expander (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .step           (u_step_if.dst),
    .i_credit       (i_credit),
    .o_op_valid     (o_op_valid),
    .o_op           (o_op),
    .o_op_units     (o_op_units),
    .o_op_in_words  (o_op_in_words),
    .o_op_out_words (o_op_out_words)
  );

endmodule

`default_nettype wire

//--- src/phase_planner.sv
`timescale 1ns/1ps
`default_nettype none

module phase_planner (
  input  logic                   clk,
  input  logic                   i_rst_n,
  input  logic                   i_cmd_valid,
  input  kem_ctrl_pkg::kem_cmd_e i_cmd,
  output logic                   o_cmd_ready,
  phase_if.src                   phase
);
  import kem_ctrl_pkg::*;

  kem_cmd_e         cmd_q;
  logic [1:0]       idx_q;
  logic [ROW_W-1:0] row_q;
  logic             valid_q;
  logic             test_q;
  logic             accept;
  logic             xfer;
  logic             last_row;
  logic             last_phase;

  assign o_cmd_ready = ~valid_q;
  assign accept      = i_cmd_valid & o_cmd_ready;
  assign xfer        = phase.valid & phase.ready;
  assign last_row    = (row_q == ROW_W'(GEN_ROWS - 1));
  assign last_phase  = (cmd_q != CMD_KEYGEN) || (idx_q == 2'd3);

  assign phase.valid = valid_q;
  assign phase.row   = row_q;

  // Phase list per command
  always_comb begin
    phase.phase = PH_ADD_ENTROPY;
    case (cmd_q)
      CMD_KEYGEN: begin
        case (idx_q)
          2'd0:    phase.phase = test_q ? PH_KEYGEN_SEEDED : PH_KEYGEN_PRNG;
          2'd1:    phase.phase = PH_KEYGEN_MID;
          2'd2:    phase.phase = PH_GEN_ROWS;
          default: phase.phase = PH_KEYGEN_POST;
        endcase
      end
      CMD_SETUP_TEST: phase.phase = PH_SETUP_TEST;
      default:        phase.phase = PH_ADD_ENTROPY;
    endcase
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cmd_q   <= CMD_KEYGEN;
      idx_q   <= '0;
      row_q   <= '0;
      valid_q <= 1'b0;
      test_q  <= 1'b0;
    end else if (accept) begin
      // cmd_q still holds the previous command here
      test_q  <= (cmd_q == CMD_SETUP_TEST);
      cmd_q   <= i_cmd;
      idx_q   <= '0;
      row_q   <= '0;
      valid_q <= 1'b1;
    end else if (xfer) begin
      if (phase.phase == PH_GEN_ROWS && !last_row) begin
        row_q <= row_q + 1'b1;
      end else if (last_phase) begin
        valid_q <= 1'b0;
      end else begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/step_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module step_sequencer (
  input  logic clk,
  input  logic i_rst_n,
  phase_if.dst phase,
  step_if.src  step
);
  import kem_ctrl_pkg::*;

  phase_e            ph_q;
  logic [ROW_W-1:0]  row_q;
  logic [STEP_W-1:0] cnt_q;
  logic              active_q;
  logic [STEP_W-1:0] len;
  step_t             st;
  logic              step_xfer;

  function automatic step_t mk(step_kind_e kind, logic last, logic sampled,
                               logic [8:0] param, mem_cmd_e mem, logic pack,
                               hub_t dst, hub_t src);
    step_t s;
    s.kind    = kind;
    s.last    = last;
    s.sampled = sampled;
    s.param   = param;
    s.mem     = mem;
    s.pack    = pack;
    s.dst     = dst;
    s.src     = src;
    return s;
  endfunction

  always_comb begin
    case (ph_q)
      PH_KEYGEN_PRNG:   len = STEP_W'(MAX_STEPS);
      PH_KEYGEN_SEEDED: len = 4'd1;
      PH_KEYGEN_MID:    len = STEP_W'(MAX_STEPS);
      PH_GEN_ROWS:      len = 4'd4;
      PH_KEYGEN_POST:   len = 4'd6;
      PH_SETUP_TEST:    len = 4'd4;
      default:          len = 4'd5;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Step table
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    st = mk(SK_GENERIC, 1'b0, 1'b0, '0, MEM_NONE, 1'b0, HUB_NONE, HUB_NONE);
    case (ph_q)
      PH_KEYGEN_PRNG: case (cnt_q)
        // Seeds from the RNG state, then advance the RNG state
        4'd0: st = mk(SK_ABSORB_BYTE, 1'b0, 1'b0, 9'h000, MEM_NONE, 1'b0, HUB_NONE, HUB_NONE);
        4'd1: st = mk(SK_GENERIC, 1'b1, 1'b0, '0, MEM_OUT_RNG_STATE, 1'b0, HUB_KECCAK, HUB_MEM);
        4'd2: st = mk(SK_K_SINGLE, 1'b0, 1'b0, '0, MEM_NONE, 1'b0, HUB_NONE, HUB_NONE);
        4'd3: st = mk(SK_GENERIC, 1'b0, 1'b0, '0, MEM_NONE, 1'b0, HUB_OUTER, HUB_KECCAK);
        4'd4: st = mk(SK_GENERIC, 1'b0, 1'b0, '0, MEM_IN_SEED_SE, 1'b0, HUB_MEM, HUB_KECCAK);
        4'd5: st = mk(SK_GENERIC, 1'b1, 1'b0, '0, MEM_NONE, 1'b0, HUB_SEED, HUB_KECCAK);
        4'd6: st = mk(SK_K_SINGLE, 1'b0, 1'b0, '0, MEM_NONE, 1'b0, HUB_NONE, HUB_NONE);
        4'd7: st = mk(SK_ABSORB_BYTE, 1'b0, 1'b0, 9'h001, MEM_NONE, 1'b0, HUB_NONE, HUB_NONE);
        4'd8: st = mk(SK_GENERIC, 1'b1, 1'b0, '0, MEM_OUT_RNG_STATE, 1'b0, HUB_KECCAK, HUB_MEM);
        default: st = mk(SK_GENERIC, 1'b1, 1'b0, '0, MEM_IN_RNG_STATE, 1'b0, HUB_MEM, HUB_KECCAK);
      endcase
      // Test mode takes the secret from the preloaded u
      PH_KEYGEN_SEEDED: st = mk(SK_GENERIC, 1'b0, 1'b0, '0, MEM_OUT_U, 1'b0, HUB_OUTER, HUB_MEM);
      PH_KEYGEN_MID: case (cnt_q)
        4'd0: st = mk(SK_K_LONG_OUT, 1'b0, 1'b0, 9'd317, MEM_NONE, 1'b0, HUB_NONE, HUB_NONE);
        4'd1: st = mk(SK_ABSORB_BYTE, 1'b0, 1'b0, 9'h05f, MEM_NONE, 1'b0, HUB_NONE, HUB_NONE);
        4'd2: st = mk(SK_GENERIC, 1'b1, 1'b0, '0, MEM_OUT_SEED_SE, 1'b0, HUB_KECCAK, HUB_MEM);
        4'd3: st = mk(SK_GENERIC, 1'b0, 1'b1, '0, MEM_IN_S_ROW, 1'b0,
                      HUB_MEM | HUB_OUTER, HUB_KECCAK);
        4'd4: st = mk(SK_GENERIC, 1'b1, 1'b1, '0, MEM_IN_B_COL, 1'b0, HUB_MEM, HUB_KECCAK);
        4'd5: st = mk(SK_K_SINGLE, 1'b0, 1'b0, '0, MEM_NONE, 1'b0, HUB_NONE, HUB_NONE);
        4'd6: st = mk(SK_GENERIC, 1'b1, 1'b0, '0, MEM_NONE, 1'b0, HUB_KECCAK, HUB_SEED);
        4'd7: st = mk(SK_GENERIC, 1'b1, 1'b0, '0, MEM_NONE, 1'b0,
                      HUB_SEED | HUB_OUTER, HUB_KECCAK);
        4'd8: st = mk(SK_K_NO_OVERLAP, 1'b0, 1'b0, '0, MEM_NONE, 1'b0, HUB_NONE, HUB_NONE);
        default: st = mk(SK_MEM_OP, 1'b0, 1'b0, '0, MEM_OP_B_PLUS_S_AT, 1'b0, HUB_NONE, HUB_NONE);
      endcase
      // One matrix row with the row index absorbed little endian
      PH_GEN_ROWS: case (cnt_q)
        4'd0: st = mk(SK_ABSORB_BYTE, 1'b0, 1'b0, {1'b0, row_q[7:0]}, MEM_NONE, 1'b0,
                      HUB_NONE, HUB_NONE);
        4'd1: st = mk(SK_ABSORB_BYTE, 1'b0, 1'b0, {1'b0, row_q[15:8]}, MEM_NONE, 1'b0,
                      HUB_NONE, HUB_NONE);
        4'd2: st = mk(SK_GENERIC, 1'b1, 1'b0, '0, MEM_NONE, 1'b0, HUB_KECCAK, HUB_SEED);
        default: st = mk(SK_GEN_ROW_OUT, 1'b1, 1'b0, '0, MEM_NONE, 1'b0, HUB_MEM, HUB_KECCAK);
      endcase
      PH_KEYGEN_POST: case (cnt_q)
        4'd0: st = mk(SK_K_NO_OVERLAP, 1'b0, 1'b0, '0, MEM_NONE, 1'b0, HUB_NONE, HUB_NONE);
        4'd1: st = mk(SK_K_LONG_IN, 1'b0, 1'b0, 9'd159, MEM_NONE, 1'b0, HUB_NONE, HUB_NONE);
        4'd2: st = mk(SK_GENERIC, 1'b0, 1'b0, '0, MEM_NONE, 1'b0, HUB_KECCAK, HUB_SEED);
        4'd3: st = mk(SK_GENERIC, 1'b1, 1'b0, '0, MEM_OUT_B_COL, 1'b1,
                      HUB_KECCAK | HUB_OUTER, HUB_MEM);
        4'd4: st = mk(SK_GENERIC, 1'b1, 1'b0, '0, MEM_NONE, 1'b0, HUB_OUTER, HUB_KECCAK);
        default: st = mk(SK_MEM_OP, 1'b0, 1'b0, '0, MEM_OP_ERASE1, 1'b0, HUB_NONE, HUB_NONE);
      endcase
      PH_SETUP_TEST: case (cnt_q)
        4'd0: st = mk(SK_GENERIC, 1'b0, 1'b0, '0, MEM_IN_SEED_SE, 1'b0, HUB_MEM, HUB_OUTER);
        4'd1: st = mk(SK_GENERIC, 1'b0, 1'b0, '0, MEM_IN_U, 1'b0, HUB_MEM, HUB_OUTER);
        4'd2: st = mk(SK_GENERIC, 1'b0, 1'b0, '0, MEM_IN_SALT, 1'b0, HUB_MEM, HUB_OUTER);
        default: st = mk(SK_GENERIC, 1'b0, 1'b0, '0, MEM_NONE, 1'b0, HUB_SEED, HUB_OUTER);
      endcase
      default: case (cnt_q)
        // RNG state mixed with 16 words of outside entropy
        4'd0: st = mk(SK_K_SINGLE, 1'b0, 1'b0, '0, MEM_NONE, 1'b0, HUB_NONE, HUB_NONE);
        4'd1: st = mk(SK_ABSORB_BYTE, 1'b0, 1'b0, 9'h005, MEM_NONE, 1'b0, HUB_NONE, HUB_NONE);
        4'd2: st = mk(SK_GENERIC, 1'b0, 1'b0, '0, MEM_OUT_RNG_STATE, 1'b0, HUB_KECCAK, HUB_MEM);
        4'd3: st = mk(SK_GENERIC, 1'b1, 1'b0, '0, MEM_NONE, 1'b0, HUB_KECCAK, HUB_OUTER);
        default: st = mk(SK_GENERIC, 1'b1, 1'b0, '0, MEM_IN_RNG_STATE, 1'b0, HUB_MEM, HUB_KECCAK);
      endcase
    endcase
  end

  assign step.valid     = active_q;
  assign step.step      = st;
  assign step.phase_end = (cnt_q == len - 1'b1);
  assign step_xfer      = step.valid & step.ready;

  // Next phase is taken in the same cycle as the final step leaves
  assign phase.ready = ~active_q | (step_xfer & step.phase_end);

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ph_q     <= PH_KEYGEN_PRNG;
      row_q    <= '0;
      cnt_q    <= '0;
      active_q <= 1'b0;
    end else if (phase.valid && phase.ready) begin
      ph_q     <= phase.phase;
      row_q    <= phase.row;
      cnt_q    <= '0;
      active_q <= 1'b1;
    end else if (step_xfer) begin
      if (step.phase_end) begin
        active_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/unit_expander.sv
`timescale 1ns/1ps
`default_nettype none

module unit_expander (
  input  logic                               clk,
  input  logic                               i_rst_n,
  step_if.dst                                step,
  input  logic                               i_credit,
  output logic                               o_op_valid,
  output kem_ctrl_pkg::step_t                o_op,
  output logic [kem_ctrl_pkg::UNIT_W-1:0]    o_op_units,
  output logic [kem_ctrl_pkg::WORDS_W-1:0]   o_op_in_words,
  output logic [kem_ctrl_pkg::WORDS_W-1:0]   o_op_out_words
);
  import kem_ctrl_pkg::*;

  logic [UNIT_W-1:0]   units;
  logic [WORDS_W-1:0]  in_words;
  logic [WORDS_W-1:0]  out_words;
  hub_t                either;
  logic                occ_q;
  logic [CREDIT_W-1:0] credit_q;
  logic                fire;
  logic                load;

  assign either = step.step.dst | step.step.src;

  // Unit-select mask from the kind and the hub route
  always_comb begin
    units = '0;
    if (step.step.kind == SK_GEN_ROW_OUT) begin
      units[UNIT_K]     = 1'b1;
      units[UNIT_H]     = 1'b1;
      units[UNIT_K_OUT] = 1'b1;
    end else begin
      units[UNIT_K_IN]  = ((step.step.dst & HUB_KECCAK) != '0) ||
                          (step.step.kind inside {SK_ABSORB_BYTE, SK_ABSORB_ZEROS});
      units[UNIT_K_OUT] = (step.step.src & HUB_KECCAK) != '0;
      units[UNIT_O_OUT] = (step.step.dst & HUB_OUTER) != '0;
      units[UNIT_O_IN]  = (step.step.src & HUB_OUTER) != '0;
      units[UNIT_M]     = ((either & HUB_MEM) != '0) || (step.step.kind == SK_MEM_OP);
      units[UNIT_S]     = (either & HUB_SEED) != '0;
      units[UNIT_H]     = either != '0;
      units[UNIT_K]     = step.step.kind inside {SK_K_SINGLE, SK_K_LONG_OUT,
                                                 SK_K_LONG_IN, SK_K_NO_OVERLAP};
    end
  end

  assign in_words  = (step.step.dst == HUB_KECCAK && step.step.src == HUB_OUTER) ?
                     WORDS_W'(IN_WORDS) : '0;
  assign out_words = (step.step.dst == HUB_OUTER && step.step.src == HUB_KECCAK) ?
                     WORDS_W'(OUT_WORDS) : '0;

  // An operation leaves only against a credit
  assign fire       = occ_q & (credit_q != '0);
  assign o_op_valid = fire;
  assign step.ready = ~occ_q | fire;
  assign load       = step.valid & step.ready;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      occ_q    <= 1'b0;
      credit_q <= CREDIT_W'(CREDITS);
    end else begin
      if (load) begin
        occ_q <= 1'b1;
      end else if (fire) begin
        occ_q <= 1'b0;
      end
      case ({fire, i_credit})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      o_op           <= step.step;
      o_op_units     <= units;
      o_op_in_words  <= in_words;
      o_op_out_words <= out_words;
    end
  end

endmodule

`default_nettype wire

//--- verif/kem_ctrl_props.sv
`timescale 1ns/1ps
`default_nettype none

module kem_ctrl_props (
  input logic                             clk,
  input logic                             i_rst_n,
  input logic                             i_credit,
  input logic                             i_cmd_ready,
  input logic                             i_op_valid,
  input kem_ctrl_pkg::step_t              i_op,
  input logic [kem_ctrl_pkg::UNIT_W-1:0]  i_op_units,
  input logic [kem_ctrl_pkg::WORDS_W-1:0] i_op_in_words,
  input logic [kem_ctrl_pkg::WORDS_W-1:0] i_op_out_words
);
  import kem_ctrl_pkg::*;

  int unsigned        outstanding;
  hub_t               any_side;
  logic [UNIT_W-1:0]  exp_units;
  logic [WORDS_W-1:0] exp_in_words;
  logic [WORDS_W-1:0] exp_out_words;
  logic               is_k_kind;

  // Reference mask built from the route and kind of the visible operation
  always_comb begin
    exp_units = '0;
    any_side  = i_op.dst | i_op.src;
    is_k_kind = (i_op.kind == SK_K_SINGLE) || (i_op.kind == SK_K_LONG_OUT) ||
                (i_op.kind == SK_K_LONG_IN) || (i_op.kind == SK_K_NO_OVERLAP);
    if (i_op.kind == SK_GEN_ROW_OUT) begin
      exp_units[UNIT_K]     = 1'b1;
      exp_units[UNIT_H]     = 1'b1;
      exp_units[UNIT_K_OUT] = 1'b1;
    end else begin
      exp_units[UNIT_K_IN]  = ((i_op.dst & HUB_KECCAK) != 0) ||
                              (i_op.kind == SK_ABSORB_BYTE) || (i_op.kind == SK_ABSORB_ZEROS);
      exp_units[UNIT_K_OUT] = (i_op.src & HUB_KECCAK) != 0;
      exp_units[UNIT_O_OUT] = (i_op.dst & HUB_OUTER) != 0;
      exp_units[UNIT_O_IN]  = (i_op.src & HUB_OUTER) != 0;
      exp_units[UNIT_M]     = ((any_side & HUB_MEM) != 0) || (i_op.kind == SK_MEM_OP);
      exp_units[UNIT_S]     = (any_side & HUB_SEED) != 0;
      exp_units[UNIT_H]     = any_side != 0;
      exp_units[UNIT_K]     = is_k_kind;
    end
    exp_in_words  = (i_op.dst == HUB_KECCAK && i_op.src == HUB_OUTER) ?
                    WORDS_W'(IN_WORDS) : '0;
    exp_out_words = (i_op.dst == HUB_OUTER && i_op.src == HUB_KECCAK) ?
                    WORDS_W'(OUT_WORDS) : '0;
  end

  // Operations sent but not yet credited back
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + (i_op_valid ? 1 : 0) - (i_credit ? 1 : 0);
    end
  end

  a_units: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_op_valid |-> (i_op_units == exp_units))
    else $error("Error at %0t: o_op_units is %b, expected %b", $time,
                $sampled(i_op_units), $sampled(exp_units));

  a_in_words: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_op_valid |-> (i_op_in_words == exp_in_words))
    else $error("Error at %0t: o_op_in_words is %0d, expected %0d", $time,
                $sampled(i_op_in_words), $sampled(exp_in_words));

  a_out_words: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_op_valid |-> (i_op_out_words == exp_out_words))
    else $error("Error at %0t: o_op_out_words is %0d, expected %0d", $time,
                $sampled(i_op_out_words), $sampled(exp_out_words));

  a_credit_cap: assert property (@(posedge clk) disable iff (!i_rst_n)
    outstanding <= CREDITS)
    else $error("Error at %0t: operations outstanding is %0d, expected at most %0d",
                $time, $sampled(outstanding), CREDITS);

  a_credit_stall: assert property (@(posedge clk) disable iff (!i_rst_n)
    (outstanding == CREDITS) |-> !i_op_valid)
    else $error("operation sent with no credit left");

  a_reset_state: assert property (@(posedge clk)
    $rose(i_rst_n) |-> i_cmd_ready && !i_op_valid)
    else $error("controller not idle when reset was released");

endmodule

`default_nettype wire

//--- verif/kem_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module kem_ctrl_tb;
  import kem_ctrl_pkg::*;

  localparam int TIMEOUT    = 1000;
  localparam int KEYGEN_OPS = 10 + 10 + 4 * GEN_ROWS + 6;
  localparam int SEEDED_OPS = 1 + 10 + 4 * GEN_ROWS + 6;

  logic               clk;
  logic               rst_n;
  logic               cmd_valid;
  kem_cmd_e           cmd;
  logic               credit;
  logic               cmd_ready;
  logic               op_valid;
  step_t              op;
  logic [UNIT_W-1:0]  op_units;
  logic [WORDS_W-1:0] op_in_words;
  logic [WORDS_W-1:0] op_out_words;

  // Operations of the current command in arrival order
  step_t       ops[$];
  int          in_words_q[$];
  int unsigned ops_total = 0;
  int unsigned credits_back;
  logic        credit_hold;
  logic        cmd_seen;

  kem_ctrl_top DUT (
    .clk            (clk),
    .i_rst_n        (rst_n),
    .i_cmd_valid    (cmd_valid),
    .i_cmd          (cmd),
    .i_credit       (credit),
    .o_cmd_ready    (cmd_ready),
    .o_op_valid     (op_valid),
    .o_op           (op),
    .o_op_units     (op_units),
    .o_op_in_words  (op_in_words),
    .o_op_out_words (op_out_words)
  );

  bind kem_ctrl_top kem_ctrl_props u_props (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_credit       (i_credit),
    .i_cmd_ready    (o_cmd_ready),
    .i_op_valid     (o_op_valid),
    .i_op           (o_op),
    .i_op_units     (o_op_units),
    .i_op_in_words  (o_op_in_words),
    .i_op_out_words (o_op_out_words)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting and checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input int got, input int exp);
    assert (got == exp) else begin
      $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_route(input int idx, input hub_t dst, input hub_t src);
    check_value($sformatf("o_op.dst of op %0d", idx), ops[idx].dst, dst);
    check_value($sformatf("o_op.src of op %0d", idx), ops[idx].src, src);
  endtask

  task automatic check_kind(input int idx, input step_kind_e kind);
    check_value($sformatf("o_op.kind of op %0d", idx), ops[idx].kind, kind);
  endtask

  // Row index goes in as two absorbed bytes with the low byte first
  task automatic check_gen_rows(input int start);
    int base;
    for (int r = 0; r < GEN_ROWS; r++) begin
      base = start + 4 * r;
      check_kind(base, SK_ABSORB_BYTE);
      check_value($sformatf("o_op.param of op %0d", base), ops[base].param, r % 256);
      check_kind(base + 1, SK_ABSORB_BYTE);
      check_value($sformatf("o_op.param of op %0d", base + 1), ops[base + 1].param, r / 256);
      check_route(base + 2, HUB_KECCAK, HUB_SEED);
      check_value($sformatf("o_op.last of op %0d", base + 2), ops[base + 2].last, 1);
      check_kind(base + 3, SK_GEN_ROW_OUT);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bounded waits on the DUT
  ////////////////////////////////////////////////////////////////////////////

  task automatic issue_command(input kem_cmd_e c);
    int n;
    n = 0;
    while (!cmd_ready) begin
      @(posedge clk);
      #1;
      n++;
      if (n > TIMEOUT) begin
        $display("Timeout: o_cmd_ready never rose for command %s", c.name());
        abort_run();
      end
    end
    cmd       = c;
    cmd_valid = 1'b1;
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
    cmd_seen  = 1'b1;
  endtask

  task automatic wait_ops(input int n_ops);
    int n;
    n = 0;
    while (ops.size() < n_ops) begin
      @(posedge clk);
      #1;
      n++;
      if (n > TIMEOUT) begin
        $display("Timeout: only %0d of %0d operations arrived", ops.size(), n_ops);
        abort_run();
      end
    end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (!(cmd_ready && ops_total == credits_back)) begin
      @(posedge clk);
      #1;
      n++;
      if (n > TIMEOUT) begin
        $display("Timeout: the controller did not go idle");
        abort_run();
      end
    end
    // Room for any extra operation to show up
    repeat (8) @(posedge clk);
    #1;
  endtask

  task automatic run_command(input kem_cmd_e c, input int n_ops);
    ops.delete();
    in_words_q.delete();
    issue_command(c);
    wait_ops(n_ops);
    wait_drained();
    check_value("operation count", ops.size(), n_ops);
  endtask

  // Operation monitor sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n && op_valid) begin
      assert (cmd_seen) else begin
        $display("o_op_valid went high before any command was accepted");
        abort_run();
      end
      assert (ops_total - credits_back < CREDITS) else begin
        $display("Error at %0t: o_op_valid is 1 with %0d operations outstanding, expected 0",
                 $time, ops_total - credits_back);
        abort_run();
      end
      ops.push_back(op);
      in_words_q.push_back(op_in_words);
      ops_total++;
    end
  end

  // Credit return after a random gap of 0 to 3 cycles
  initial begin : credit_driver
    int unsigned gap;
    void'($urandom(32'hb8e7));
    credit       = 1'b0;
    credits_back = 0;
    gap          = 0;
    forever begin
      @(posedge clk);
      #1;
      credit = 1'b0;
      if (!credit_hold && ops_total > credits_back) begin
        if (gap == 0) begin
          credit = 1'b1;
          credits_back++;
          gap = $urandom % 4;
        end else begin
          gap--;
        end
      end
    end
  end

  initial begin : main_sequence
    int n;
    rst_n       = 1'b0;
    cmd_valid   = 1'b0;
    cmd         = CMD_KEYGEN;
    credit_hold = 1'b0;
    cmd_seen    = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_value("o_cmd_ready", cmd_ready, 1);
    check_value("o_op_valid", op_valid, 0);
    repeat (5) @(posedge clk);
    #1;

    // Plain keygen on the PRNG path
    run_command(CMD_KEYGEN, KEYGEN_OPS);
    check_kind(KEYGEN_OPS - 1, SK_MEM_OP);
    check_value("o_op.mem of the last op", ops[KEYGEN_OPS - 1].mem, MEM_OP_ERASE1);
    check_gen_rows(20);

    run_command(CMD_ADD_ENTROPY, 5);
    check_kind(0, SK_K_SINGLE);
    check_kind(1, SK_ABSORB_BYTE);
    check_value("o_op.param of op 1", ops[1].param, 5);
    check_route(2, HUB_KECCAK, HUB_MEM);
    check_route(3, HUB_KECCAK, HUB_OUTER);
    check_value("o_op.last of op 3", ops[3].last, 1);
    check_value("o_op_in_words of op 3", in_words_q[3], IN_WORDS);
    check_route(4, HUB_MEM, HUB_KECCAK);

    // Test mode with setupTest then a seeded keygen
    run_command(CMD_SETUP_TEST, 4);
    check_route(3, HUB_SEED, HUB_OUTER);
    run_command(CMD_KEYGEN, SEEDED_OPS);
    check_value("o_op.mem of op 0", ops[0].mem, MEM_OUT_U);
    check_route(0, HUB_OUTER, HUB_MEM);
    check_gen_rows(11);

    // Credits withheld until the queue limit is reached
    credit_hold = 1'b1;
    ops.delete();
    in_words_q.delete();
    issue_command(CMD_KEYGEN);
    n = 0;
    while (ops_total - credits_back < CREDITS) begin
      @(posedge clk);
      #1;
      n++;
      if (n > TIMEOUT) begin
        $display("Timeout: the credits were never used up");
        abort_run();
      end
    end
    repeat (20) @(posedge clk);
    #1;
    check_value("operations outstanding", ops.size(), CREDITS);
    credit_hold = 1'b0;
    wait_ops(KEYGEN_OPS);
    wait_drained();
    check_value("operation count", ops.size(), KEYGEN_OPS);
    check_value("o_op.mem of the last op", ops[KEYGEN_OPS - 1].mem, MEM_OP_ERASE1);

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire
